// ==== stopwatch.f ====
+incdir+verilog
verilog/stopwatch_pkg.sv
verilog/stopwatch_regs.sv
verilog/tick_gen.sv
verilog/bcd_time_counter.sv
verilog/display_scan.sv
verilog/stopwatch_top.sv
sim/stopwatch_properties.sv
sim/stopwatch_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= stopwatch_tb
FLIST     ?= stopwatch.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FLIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG) || ! grep -q "ALL TESTS PASSED" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	else \
	  echo "simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/stopwatch_tb.sv ====
`timescale 1ns/10ps
`include "stopwatch_settings.svh"

module stopwatch_tb
  import stopwatch_pkg::*;
();

  logic       clk_in;
  logic       reset;
  logic       psel;
  logic       penable;
  logic       pwrite;
  apb_addr_t  paddr;
  apb_data_t  pwdata;
  apb_data_t  prdata;
  logic       pready;
  logic       pslverr;
  seg_t       seg;
  digit_sel_t digit;

  int         errors;
  int         checks;
  integer     seed;
  logic       bus_err;

  stopwatch_top u_dut (
    .clk_in  (clk_in),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .seg     (seg),
    .digit   (digit)
  );

  initial
  begin
    clk_in = 1'b0;
    forever #4 clk_in = ~clk_in;
  end

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////
  function automatic bcd_time_t make_time(input int mins, input int secs);
    bcd_time_t t;
    t.min_tens = 3'(mins / 10);
    t.min_ones = 4'(mins % 10);
    t.sec_tens = 3'(secs / 10);
    t.sec_ones = 4'(secs % 10);
    return t;
  endfunction

  function automatic int total_secs(input bcd_time_t t);
    return (int'(t.min_tens) * 10 + int'(t.min_ones)) * 60 +
           int'(t.sec_tens) * 10 + int'(t.sec_ones);
  endfunction

  // one second on, held at 00:00 and 59:59
  function automatic bcd_time_t step_time(input bcd_time_t t, input logic down);
    int s;
    s = total_secs(t);
    if (down)
      s = (s > 0) ? s - 1 : 0;
    else
      s = (s < 3599) ? s + 1 : 3599;
    return make_time(s / 60, s % 60);
  endfunction

  // bus format, one nibble per digit
  function automatic apb_data_t time_to_word(input bcd_time_t t);
    return apb_data_t'({1'b0, t.min_tens, t.min_ones, 1'b0, t.sec_tens, t.sec_ones});
  endfunction

  function automatic bcd_time_t word_to_time(input apb_data_t d);
    bcd_time_t t;
    t.min_tens = d[14:12];
    t.min_ones = d[11:8];
    t.sec_tens = d[6:4];
    t.sec_ones = d[3:0];
    return t;
  endfunction

  // lit segments gfedcba, inverted for the active low outputs
  function automatic seg_t seg_for(input logic [3:0] d);
    logic [6:0] lit;
    case (d)
      4'd0:    lit = 7'b0111111;
      4'd1:    lit = 7'b0000110;
      4'd2:    lit = 7'b1011011;
      4'd3:    lit = 7'b1001111;
      4'd4:    lit = 7'b1100110;
      4'd5:    lit = 7'b1101101;
      4'd6:    lit = 7'b1111101;
      4'd7:    lit = 7'b0000111;
      4'd8:    lit = 7'b1111111;
      4'd9:    lit = 7'b1101111;
      default: lit = 7'b0000000;
    endcase
    return ~lit;
  endfunction

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////
  task automatic compare_time(input string name, input bcd_time_t got, input bcd_time_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED %s: got 0x%h, expected 0x%h", name, time_to_word(got),
               time_to_word(exp));
    end
  endtask

  task automatic compare_data(input string name, input apb_data_t got, input apb_data_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic compare_seg(input string name, input seg_t got, input seg_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  ////////////////////////////////////////
  // apb transfers
  ////////////////////////////////////////
  task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
    @(posedge clk_in);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk_in);
    penable <= 1'b1;
    @(negedge clk_in);
    bus_err = pslverr;
    compare_flag("pready", pready, 1'b1);
    @(posedge clk_in);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t data);
    @(posedge clk_in);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clk_in);
    penable <= 1'b1;
    // access phase, sampled mid cycle
    @(negedge clk_in);
    data    = prdata;
    bus_err = pslverr;
    compare_flag("pready", pready, 1'b1);
    @(posedge clk_in);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  // each read must match the last one or be one step on
  task automatic poll_time(input bcd_time_t target, input logic down, input int max_reads);
    apb_data_t word;
    bcd_time_t prev;
    bcd_time_t now;
    int        n;
    apb_read(`SW_ADDR_TIME, word);
    prev = word_to_time(word);
    n = 0;
    while ((prev !== target) && (n < max_reads))
    begin
      apb_read(`SW_ADDR_TIME, word);
      now = word_to_time(word);
      if ((now !== prev) && (now !== step_time(prev, down)))
        compare_time("time step", now, step_time(prev, down));
      prev = now;
      n++;
    end
    if (prev !== target)
    begin
      errors++;
      $display("timeout: TIME did not reach 0x%h in %0d reads", time_to_word(target),
               max_reads);
    end
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////
  task automatic reset_and_errors();
    apb_data_t d;
    apb_read(`SW_ADDR_CTRL, d);
    compare_data("ctrl", d, '0);
    apb_read(`SW_ADDR_TICK_DIV, d);
    compare_data("tick_div", d, apb_data_t'(`SW_TICK_DIV_RESET));
    apb_read(`SW_ADDR_TIME, d);
    compare_data("time", d, '0);
    compare_flag("pslverr", bus_err, 1'b0);
    apb_read(4'h2, d);
    compare_flag("pslverr", bus_err, 1'b1);
    compare_data("prdata", d, '0);
    // unmapped write must not reach ctrl
    apb_write(4'h6, 32'h3);
    compare_flag("pslverr", bus_err, 1'b1);
    apb_read(`SW_ADDR_CTRL, d);
    compare_data("ctrl", d, '0);
  endtask

  task automatic count_up_carries();
    apb_write(`SW_ADDR_TIME, time_to_word(make_time(0, 58)));
    apb_write(`SW_ADDR_TICK_DIV, 32'd3);
    apb_write(`SW_ADDR_CTRL, 32'h1);
    poll_time(make_time(1, 1), 1'b0, 50);
    apb_write(`SW_ADDR_CTRL, 32'h0);
  endtask

  task automatic count_down_saturation();
    apb_data_t d;
    apb_write(`SW_ADDR_CTRL, 32'h2);
    apb_write(`SW_ADDR_TIME, time_to_word(make_time(0, 2)));
    apb_write(`SW_ADDR_CTRL, 32'h3);
    poll_time(make_time(0, 0), 1'b1, 50);
    repeat (50) @(posedge clk_in);
    apb_read(`SW_ADDR_TIME, d);
    compare_time("time", word_to_time(d), make_time(0, 0));
    // first write stops, second clears dir
    apb_write(`SW_ADDR_CTRL, 32'h0);
    apb_write(`SW_ADDR_CTRL, 32'h0);
    apb_write(`SW_ADDR_TIME, time_to_word(make_time(59, 58)));
    apb_write(`SW_ADDR_CTRL, 32'h1);
    poll_time(make_time(59, 59), 1'b0, 50);
    repeat (50) @(posedge clk_in);
    apb_read(`SW_ADDR_TIME, d);
    compare_time("time", word_to_time(d), make_time(59, 59));
    apb_write(`SW_ADDR_CTRL, 32'h0);
  endtask

  task automatic direction_lock();
    apb_data_t d;
    bcd_time_t t;
    apb_write(`SW_ADDR_TIME, time_to_word(make_time(10, 0)));
    apb_write(`SW_ADDR_CTRL, 32'h1);
    apb_write(`SW_ADDR_CTRL, 32'h3);
    apb_read(`SW_ADDR_CTRL, d);
    compare_data("ctrl", d, 32'h1);
    apb_read(`SW_ADDR_TIME, d);
    t = word_to_time(d);
    poll_time(step_time(t, 1'b0), 1'b0, 20);
    apb_write(`SW_ADDR_CTRL, 32'h0);
    apb_write(`SW_ADDR_CTRL, 32'h2);
    apb_read(`SW_ADDR_CTRL, d);
    compare_data("ctrl", d, 32'h2);
  endtask

  task automatic two_minute_jump();
    apb_data_t d;
    int        m;
    int        s;
    int        i;
    for (i = 0; i < 4; i++)
    begin
      m = 2 + (($random(seed) & 32'h7fff_ffff) % 56);
      s = ($random(seed) & 32'h7fff_ffff) % 60;
      apb_write(`SW_ADDR_CTRL, 32'h0);
      apb_write(`SW_ADDR_TIME, time_to_word(make_time(m, s)));
      apb_write(`SW_ADDR_JUMP, 32'h1);
      apb_read(`SW_ADDR_TIME, d);
      compare_time("time", word_to_time(d), make_time(m + `SW_JUMP_MIN, s));
      apb_write(`SW_ADDR_CTRL, 32'h2);
      apb_write(`SW_ADDR_JUMP, 32'h1);
      apb_read(`SW_ADDR_TIME, d);
      compare_time("time", word_to_time(d), make_time(m, s));
    end
    apb_read(`SW_ADDR_JUMP, d);
    compare_data("jump", d, '0);
    // jumps past either limit are dropped
    apb_write(`SW_ADDR_CTRL, 32'h0);
    apb_write(`SW_ADDR_TIME, time_to_word(make_time(58, s)));
    apb_write(`SW_ADDR_JUMP, 32'h1);
    apb_read(`SW_ADDR_TIME, d);
    compare_time("time", word_to_time(d), make_time(58, s));
    apb_write(`SW_ADDR_CTRL, 32'h2);
    apb_write(`SW_ADDR_TIME, time_to_word(make_time(1, s)));
    apb_write(`SW_ADDR_JUMP, 32'h1);
    apb_read(`SW_ADDR_TIME, d);
    compare_time("time", word_to_time(d), make_time(1, s));
  endtask

  task automatic display_decode();
    apb_data_t  d;
    bcd_time_t  t;
    logic [3:0] nib;
    digit_sel_t seen;
    int         i;
    t = make_time(47, 36);
    apb_write(`SW_ADDR_CTRL, 32'h0);
    apb_write(`SW_ADDR_TIME, time_to_word(t));
    apb_read(`SW_ADDR_TIME, d);
    compare_time("time", word_to_time(d), t);
    seen = '0;
    for (i = 0; i < 64; i++)
    begin
      @(negedge clk_in);
      case (digit)
        4'b0001: nib = t.sec_ones;
        4'b0010: nib = {1'b0, t.sec_tens};
        4'b0100: nib = t.min_ones;
        4'b1000: nib = {1'b0, t.min_tens};
        default: nib = 4'hf;
      endcase
      if (nib == 4'hf)
      begin
        errors++;
        $display("FAILED digit: got 0x%h, expected a one-hot value", digit);
      end
      else
        compare_seg("seg", seg, seg_for(nib));
      seen = seen | digit;
    end
    if (seen != 4'hf)
    begin
      errors++;
      $display("timeout: only digits %b were scanned in 64 cycles", seen);
    end
  endtask

  initial
  begin
    seed    = 32'h8c53_a6b8;
    errors  = 0;
    checks  = 0;
    bus_err = 1'b0;
    reset   = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (5) @(posedge clk_in);
    reset <= 1'b0;
    reset_and_errors();
    count_up_carries();
    count_down_saturation();
    direction_lock();
    two_minute_jump();
    display_decode();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// ==== sim/stopwatch_properties.sv ====
`timescale 1ns/10ps
`include "stopwatch_settings.svh"

module stopwatch_properties
  import stopwatch_pkg::*;
(
  input logic       clk_in,
  input logic       reset,
  input logic       load,
  input logic       jump,
  input logic       tick,
  input bcd_time_t  cur_time,
  input digit_sel_t digit
);

  localparam logic [2:0] MAX_TENS = 3'(`SW_MAX_TENS);

  // every digit a legal bcd value
  a_time_valid: assert property (
    @(posedge clk_in) disable iff (reset)
      (cur_time.min_tens <= MAX_TENS) && (cur_time.min_ones <= 4'd9) &&
      (cur_time.sec_tens <= MAX_TENS) && (cur_time.sec_ones <= 4'd9)
  ) else $error("time field out of range: %h", cur_time);

  // scan holds or moves up one digit, 3 wraps to 0
  a_digit_order: assert property (
    @(posedge clk_in) disable iff (reset)
      $onehot(digit) &&
      ((digit == $past(digit)) || (digit == {$past(digit[2:0]), $past(digit[3])}))
  ) else $error("digit select out of order: %b", digit);

  // time only moves on load, jump or tick
  a_time_hold: assert property (
    @(posedge clk_in) disable iff (reset)
      (!load && !jump && !tick) |=> $stable(cur_time)
  ) else $error("time changed without load, jump or tick");

endmodule

bind stopwatch_top stopwatch_properties u_props (
  .clk_in   (clk_in),
  .reset    (reset),
  .load     (load),
  .jump     (jump),
  .tick     (tick),
  .cur_time (cur_time),
  .digit    (digit)
);

// ==== verilog/stopwatch_top.sv ====
`timescale 1ns/10ps
`include "stopwatch_settings.svh"

module stopwatch_top
  import stopwatch_pkg::*;
(
  input  logic       clk_in,
  input  logic       reset,
  input  logic       psel,
  input  logic       penable,
  input  logic       pwrite,
  input  apb_addr_t  paddr,
  input  apb_data_t  pwdata,
  output apb_data_t  prdata,
  output logic       pready,
  output logic       pslverr,
  output seg_t       seg,
  output digit_sel_t digit
);

  logic                      run;
  logic                      dir;
  logic                      load;
  logic                      jump;
  logic                      tick;
  logic [`SW_TICK_DIV_W-1:0] tick_div;
  bcd_time_t                 load_time;
  bcd_time_t                 cur_time;

  stopwatch_regs u_regs (
    .clk_in    (clk_in),
    .reset     (reset),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .cur_time  (cur_time),
    .run       (run),
    .dir       (dir),
    .load      (load),
    .jump      (jump),
    .load_time (load_time),
    .tick_div  (tick_div)
  );

  tick_gen u_tick (
    .clk_in   (clk_in),
    .reset    (reset),
    .run      (run),
    .tick_div (tick_div),
    .tick     (tick)
  );

  bcd_time_counter u_counter (
    .clk_in    (clk_in),
    .reset     (reset),
    .tick      (tick),
    .jump      (jump),
    .dir       (dir),
    .load      (load),
    .load_time (load_time),
    .cur_time  (cur_time)
  );

  display_scan u_scan (
    .clk_in   (clk_in),
    .reset    (reset),
    .cur_time (cur_time),
    .seg      (seg),
    .digit    (digit)
  );

endmodule

// ==== verilog/display_scan.sv ====
`timescale 1ns/10ps
`include "stopwatch_settings.svh"

module display_scan
  import stopwatch_pkg::*;
(
  input  logic       clk_in,
  input  logic       reset,
  input  bcd_time_t  cur_time,
  output seg_t       seg,
  output digit_sel_t digit
);

  localparam int SCAN_W = $clog2(`SW_SCAN_DIV);

  logic [SCAN_W-1:0] scan_cnt;
  logic [1:0]        ptr;
  logic [3:0]        nibble;

  ////////////////////////////////////////
  // scan timing
  ////////////////////////////////////////
  always_ff @(posedge clk_in or posedge reset)
  begin
    if (reset)
    begin
      scan_cnt <= '0;
      ptr      <= 2'd0;
    end
    else if (scan_cnt == SCAN_W'(`SW_SCAN_DIV - 1))
    begin
      scan_cnt <= '0;
      ptr      <= ptr + 2'd1;
    end
    else
      scan_cnt <= scan_cnt + 1'b1;
  end

  assign digit = digit_sel_t'(4'b0001 << ptr);

  // pointer 0 is the seconds ones digit
  always_comb
  begin
    case (ptr)
      2'd0:    nibble = cur_time.sec_ones;
      2'd1:    nibble = {1'b0, cur_time.sec_tens};
      2'd2:    nibble = cur_time.min_ones;
      default: nibble = {1'b0, cur_time.min_tens};
    endcase
  end

  // gfedcba, a zero lights the segment
  always_comb
  begin
    case (nibble)
      4'd0:    seg = 7'h40;
      4'd1:    seg = 7'h79;
      4'd2:    seg = 7'h24;
      4'd3:    seg = 7'h30;
      4'd4:    seg = 7'h19;
      4'd5:    seg = 7'h12;
      4'd6:    seg = 7'h02;
      4'd7:    seg = 7'h78;
      4'd8:    seg = 7'h00;
      4'd9:    seg = 7'h10;
      default: seg = 7'h7f;
    endcase
  end

endmodule

// ==== verilog/bcd_time_counter.sv ====
`timescale 1ns/10ps
`include "stopwatch_settings.svh"

module bcd_time_counter
  import stopwatch_pkg::*;
(
  input  logic      clk_in,
  input  logic      reset,
  input  logic      tick,
  input  logic      jump,
  input  logic      dir,
  input  logic      load,
  input  bcd_time_t load_time,
  output bcd_time_t cur_time
);

  localparam logic [2:0] MAX_TENS = 3'(`SW_MAX_TENS);
  localparam logic [3:0] JUMP_MIN = 4'(`SW_JUMP_MIN);

  bcd_time_t   tick_time;
  bcd_time_t   jump_time;
  logic        at_max;
  logic        at_min;
  logic        jump_ok;
  logic [4:0]  min_sum;

  assign at_max = (cur_time.min_tens == MAX_TENS) && (cur_time.min_ones == 4'd9) &&
                  (cur_time.sec_tens == MAX_TENS) && (cur_time.sec_ones == 4'd9);
  assign at_min = (cur_time == '0);

  ////////////////////////////////////////
  // one second step
  ////////////////////////////////////////
  always_comb
  begin
    tick_time = cur_time;
    if (!dir)
    begin
      // count up, carry ripples through the digits
      if (cur_time.sec_ones != 4'd9)
        tick_time.sec_ones = cur_time.sec_ones + 4'd1;
      else
      begin
        tick_time.sec_ones = 4'd0;
        if (cur_time.sec_tens != MAX_TENS)
          tick_time.sec_tens = cur_time.sec_tens + 3'd1;
        else
        begin
          tick_time.sec_tens = 3'd0;
          if (cur_time.min_ones != 4'd9)
            tick_time.min_ones = cur_time.min_ones + 4'd1;
          else
          begin
            tick_time.min_ones = 4'd0;
            tick_time.min_tens = cur_time.min_tens + 3'd1;
          end
        end
      end
    end
    else
    begin
      // count down with borrow
      if (cur_time.sec_ones != 4'd0)
        tick_time.sec_ones = cur_time.sec_ones - 4'd1;
      else
      begin
        tick_time.sec_ones = 4'd9;
        if (cur_time.sec_tens != 3'd0)
          tick_time.sec_tens = cur_time.sec_tens - 3'd1;
        else
        begin
          tick_time.sec_tens = MAX_TENS;
          if (cur_time.min_ones != 4'd0)
            tick_time.min_ones = cur_time.min_ones - 4'd1;
          else
          begin
            tick_time.min_ones = 4'd9;
            tick_time.min_tens = cur_time.min_tens - 3'd1;
          end
        end
      end
    end
  end

  ////////////////////////////////////////
  // minute jump
  ////////////////////////////////////////
  assign min_sum = {1'b0, cur_time.min_ones} + {1'b0, JUMP_MIN};

  always_comb
  begin
    jump_time = cur_time;
    jump_ok   = 1'b1;
    if (!dir)
    begin
      if (min_sum > 5'd9)
      begin
        jump_time.min_ones = 4'(min_sum - 5'd10);
        jump_time.min_tens = cur_time.min_tens + 3'd1;
        // would pass 59
        jump_ok = (cur_time.min_tens != MAX_TENS);
      end
      else
        jump_time.min_ones = min_sum[3:0];
    end
    else
    begin
      if (cur_time.min_ones >= JUMP_MIN)
        jump_time.min_ones = cur_time.min_ones - JUMP_MIN;
      else
      begin
        jump_time.min_ones = cur_time.min_ones + 4'd10 - JUMP_MIN;
        jump_time.min_tens = cur_time.min_tens - 3'd1;
        // would go below 00
        jump_ok = (cur_time.min_tens != 3'd0);
      end
    end
  end

  // load beats jump, jump swallows a coincident tick
  always_ff @(posedge clk_in or posedge reset)
  begin
    if (reset)
      cur_time <= '0;
    else if (load)
      cur_time <= load_time;
    else if (jump)
    begin
      if (jump_ok)
        cur_time <= jump_time;
    end
    else if (tick && !(dir ? at_min : at_max))
      cur_time <= tick_time;
  end

endmodule

// ==== verilog/tick_gen.sv ====
`timescale 1ns/10ps
`include "stopwatch_settings.svh"

module tick_gen (
  input  logic                      clk_in,
  input  logic                      reset,
  input  logic                      run,
  input  logic [`SW_TICK_DIV_W-1:0] tick_div,
  output logic                      tick
);

  logic [`SW_TICK_DIV_W-1:0] cnt;

  // fires on the first cycle of run, then every tick_div+1 cycles
  assign tick = run && (cnt == '0);

  always_ff @(posedge clk_in or posedge reset)
  begin
    if (reset)
      cnt <= '0;
    else if (!run)
      cnt <= '0;
    else if (cnt == '0)
      cnt <= tick_div;
    else
      cnt <= cnt - 1'b1;
  end

endmodule

// ==== verilog/stopwatch_regs.sv ====
`timescale 1ns/10ps
`include "stopwatch_settings.svh"

module stopwatch_regs
  import stopwatch_pkg::*;
(
  input  logic                      clk_in,
  input  logic                      reset,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  apb_addr_t                 paddr,
  input  apb_data_t                 pwdata,
  output apb_data_t                 prdata,
  output logic                      pready,
  output logic                      pslverr,
  input  bcd_time_t                 cur_time,
  output logic                      run,
  output logic                      dir,
  output logic                      load,
  output logic                      jump,
  output bcd_time_t                 load_time,
  output logic [`SW_TICK_DIV_W-1:0] tick_div
);

  logic        access;
  logic        mapped;
  logic        wr_en;
  logic [15:0] time_nibbles;

  // no wait states
  assign pready = 1'b1;

  always_comb
  begin
    case (paddr)
      `SW_ADDR_CTRL,
      `SW_ADDR_TICK_DIV,
      `SW_ADDR_TIME,
      `SW_ADDR_JUMP: mapped = 1'b1;
      default:       mapped = 1'b0;
    endcase
  end

  assign access  = psel && penable;
  assign pslverr = access && !mapped;
  assign wr_en   = access && pwrite && mapped;

  // one nibble per digit on the bus
  assign time_nibbles = {1'b0, cur_time.min_tens, cur_time.min_ones,
                         1'b0, cur_time.sec_tens, cur_time.sec_ones};

  ////////////////////////////////////////
  // read mux
  ////////////////////////////////////////
  always_comb
  begin
    case (paddr)
      `SW_ADDR_CTRL:     prdata = apb_data_t'({dir, run});
      `SW_ADDR_TICK_DIV: prdata = apb_data_t'(tick_div);
      `SW_ADDR_TIME:     prdata = apb_data_t'(time_nibbles);
      // jump reads zero, as does anything unmapped
      default:           prdata = '0;
    endcase
  end

  ////////////////////////////////////////
  // control registers and pulses
  ////////////////////////////////////////
  always_ff @(posedge clk_in or posedge reset)
  begin
    if (reset)
    begin
      run      <= 1'b0;
      dir      <= 1'b0;
      tick_div <= `SW_TICK_DIV_W'(`SW_TICK_DIV_RESET);
      load     <= 1'b0;
      jump     <= 1'b0;
    end
    else
    begin
      // preset only accepted while stopped
      load <= wr_en && (paddr == `SW_ADDR_TIME) && !run;
      jump <= wr_en && (paddr == `SW_ADDR_JUMP) && pwdata[0];
      if (wr_en && (paddr == `SW_ADDR_CTRL))
      begin
        run <= pwdata[0];
        // direction locked while running
        if (!run)
          dir <= pwdata[1];
      end
      if (wr_en && (paddr == `SW_ADDR_TICK_DIV))
        tick_div <= pwdata[`SW_TICK_DIV_W-1:0];
    end
  end

  // preset value, fields masked to their widths
  always_ff @(posedge clk_in)
  begin
    if (wr_en && (paddr == `SW_ADDR_TIME))
    begin
      load_time.min_tens <= pwdata[14:12];
      load_time.min_ones <= pwdata[11:8];
      load_time.sec_tens <= pwdata[6:4];
      load_time.sec_ones <= pwdata[3:0];
    end
  end

endmodule

// ==== verilog/stopwatch_pkg.sv ====
`include "stopwatch_settings.svh"

package stopwatch_pkg;

  // mm:ss in bcd, tens digits only need 3 bits
  typedef struct packed {
    logic [2:0] min_tens;
    logic [3:0] min_ones;
    logic [2:0] sec_tens;
    logic [3:0] sec_ones;
  } bcd_time_t;

  // gfedcba, active low
  typedef logic [6:0] seg_t;

  // one-hot, bit 3 is minute tens
  typedef logic [3:0] digit_sel_t;

  ////////////////////////////////////////
  // apb
  ////////////////////////////////////////
  typedef logic [`SW_APB_ADDR_W-1:0] apb_addr_t;
  typedef logic [`SW_APB_DATA_W-1:0] apb_data_t;

endpackage

// ==== verilog/stopwatch_settings.svh ====
`ifndef STOPWATCH_SETTINGS_SVH
`define STOPWATCH_SETTINGS_SVH

////////////////////////////////////////
// bus widths
////////////////////////////////////////
`define SW_APB_ADDR_W 4
`define SW_APB_DATA_W 32

// register offsets
`define SW_ADDR_CTRL     4'h0
`define SW_ADDR_TICK_DIV 4'h4
`define SW_ADDR_TIME     4'h8
`define SW_ADDR_JUMP     4'hC

////////////////////////////////////////
// timing and limits
////////////////////////////////////////
`define SW_TICK_DIV_W     16
`define SW_TICK_DIV_RESET 9
`define SW_SCAN_DIV       4
`define SW_MAX_TENS       5
`define SW_JUMP_MIN       2

`endif
